/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int LEN_LINE = 4;
    localparam int LEN_INDEX = 3;
    localparam int LEN_TAG = 32 - LEN_LINE - LEN_INDEX;
    localparam int NR_WORDS = 4;
    localparam int LEN_WORD_SEL = LEN_LINE - 2;
    localparam int NR_SETS = 8;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/burst_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_counter
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    step,
    input  logic                    clear,
    output logic [LEN_WORD_SEL-1:0] count,
    output logic                    last
);

    // clear wins over a beat in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + LEN_WORD_SEL'(1);
        end
    end

    assign last = (count == LEN_WORD_SEL'(NR_WORDS - 1));

endmodule

`default_nettype wire

/* verilog/tag_store.sv */
`timescale 1ns/1ns
`default_nettype none

module tag_store
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lookup,
    input  logic [LEN_INDEX-1:0] index,
    input  logic [LEN_TAG-1:0]   tag,
    input  logic                 tag_write,
    input  logic                 refill_way,
    input  logic                 mark_dirty,
    input  logic                 dirty_way,
    output logic                 hit,
    output logic                 hit_way,
    output logic                 victim_way,
    output logic                 victim_dirty,
    output logic [LEN_TAG-1:0]   victim_tag
);

    logic [LEN_TAG-1:0] tags [2][NR_SETS];
    logic [1:0]         valid_bits [NR_SETS];
    logic [1:0]         dirty_bits [NR_SETS];
    logic [1:0]         lru_bits [NR_SETS];

    logic [LEN_TAG-1:0] tag_q [2];
    logic [LEN_TAG-1:0] req_tag;
    logic [1:0]         valid_q;
    logic [1:0]         dirty_q;
    logic [1:0]         lru_q;
    logic               lookup_q;
    logic [1:0]         match;

    always_ff @(posedge clk) begin
        if (lookup) begin
            tag_q[0] <= tags[0][index];
            tag_q[1] <= tags[1][index];
            req_tag <= tag;
            valid_q <= valid_bits[index];
            dirty_q <= dirty_bits[index];
            lru_q <= lru_bits[index];
        end
        if (tag_write) begin
            tags[refill_way][index] <= req_tag;
        end
    end

    // lru bit set marks the way to replace next
    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_q <= 1'b0;
            for (int s = 0; s < NR_SETS; s++) begin
                valid_bits[s] <= 2'b00;
                dirty_bits[s] <= 2'b00;
                lru_bits[s] <= 2'b00;
            end
        end else begin
            lookup_q <= lookup;
            if (lookup_q && hit) begin
                lru_bits[index] <= hit_way ? 2'b01 : 2'b10;
            end
            if (tag_write) begin
                valid_bits[index][refill_way] <= 1'b1;
                dirty_bits[index][refill_way] <= 1'b0;
                lru_bits[index] <= refill_way ? 2'b01 : 2'b10;
            end
            // a store miss sets dirty on top of the refill
            if (mark_dirty) begin
                dirty_bits[index][dirty_way] <= 1'b1;
            end
        end
    end

    assign match[0] = valid_q[0] && (tag_q[0] == req_tag);
    assign match[1] = valid_q[1] && (tag_q[1] == req_tag);
    assign hit = |match;
    assign hit_way = match[1];

    // dirty is only ever set on a valid line
    assign victim_way = lru_q[1];
    assign victim_dirty = dirty_q[victim_way];
    assign victim_tag = tag_q[victim_way];

endmodule

`default_nettype wire

/* verilog/data_store.sv */
`timescale 1ns/1ns
`default_nettype none

module data_store
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic [LEN_INDEX-1:0]    index,
    input  logic [LEN_WORD_SEL-1:0] word_sel,
    input  logic                    way,
    input  logic                    write,
    input  logic [3:0]              write_bytes,
    input  logic [31:0]             write_data,
    output logic [31:0]             read_word
);

    localparam int LEN_WORD_ADDR = 1 + LEN_INDEX + LEN_WORD_SEL;

    // both ways in one array, way is the top address bit
    logic [31:0]              words [2 * NR_SETS * NR_WORDS];
    logic [LEN_WORD_ADDR-1:0] word_addr;

    assign word_addr = {way, index, word_sel};

    // read returns the old word when it hits a write in the same cycle
    always_ff @(posedge clk) begin
        read_word <= words[word_addr];
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (write_bytes[b]) begin
                    words[word_addr][8*b +: 8] <= write_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    wr,
    input  logic [31:0]             addr,
    input  logic [3:0]              wstrb,
    input  logic [31:0]             wdata,
    input  logic                    hit,
    input  logic                    hit_way,
    input  logic                    victim_way,
    input  logic                    victim_dirty,
    input  logic [LEN_TAG-1:0]      victim_tag,
    input  logic [31:0]             read_word,
    input  logic                    beat_last,
    input  logic [LEN_WORD_SEL-1:0] count,
    input  logic                    arready,
    input  logic                    rvalid,
    input  logic                    rlast,
    input  logic [31:0]             rdata_m,
    input  logic                    awready,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    busy,
    output logic                    done,
    output logic [31:0]             rdata,
    output logic [31:0]             araddr,
    output logic [7:0]              arlen,
    output logic                    arvalid,
    output logic                    rready,
    output logic [31:0]             awaddr,
    output logic [7:0]              awlen,
    output logic                    awvalid,
    output logic [31:0]             wdata_m,
    output logic                    wlast,
    output logic                    wvalid,
    output logic                    lookup,
    output logic [LEN_INDEX-1:0]    index,
    output logic [LEN_WORD_SEL-1:0] word_sel,
    output logic                    tag_write,
    output logic                    refill_way,
    output logic                    mark_dirty,
    output logic                    data_write,
    output logic                    write_way,
    output logic [31:0]             write_data,
    output logic [3:0]              write_bytes,
    output logic                    count_step,
    output logic                    count_clear
);

    ctrl_state_t             state;
    logic [31:2]             req_addr;
    logic                    req_wr;
    logic [3:0]              req_wstrb;
    logic [31:0]             req_wdata;
    logic [LEN_INDEX-1:0]    req_index;
    logic [LEN_WORD_SEL-1:0] req_word;
    logic [3:0]              store_bytes;
    logic [31:0]             rdata_q;
    logic                    from_hit;
    logic                    w_done;
    logic                    w_finish;
    logic                    req_beat;

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  bytes
    );
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (bytes[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign req_index = req_addr[LEN_LINE +: LEN_INDEX];
    assign req_word = req_addr[2 +: LEN_WORD_SEL];
    assign store_bytes = req_wstrb & {4{req_wr}};

    assign busy = (state != IDLE);
    assign lookup = (state == IDLE) && en;
    assign index = (state == IDLE) ? addr[LEN_LINE +: LEN_INDEX] : req_index;
    assign word_sel = (state == IDLE)   ? addr[2 +: LEN_WORD_SEL] :
                      (state == LOOKUP) ? req_word : count;
    assign write_way = (state == LOOKUP) ? hit_way : victim_way;
    assign refill_way = victim_way;

    // line-aligned bursts, always full lines
    assign araddr = {req_addr[31:LEN_LINE], {LEN_LINE{1'b0}}};
    assign awaddr = {victim_tag, req_index, {LEN_LINE{1'b0}}};
    assign arlen = 8'(NR_WORDS - 1);
    assign awlen = 8'(NR_WORDS - 1);
    assign wdata_m = read_word;
    assign wlast = wvalid && beat_last;

    assign count_step = (wvalid && wready) || (rvalid && rready);
    assign w_finish = wvalid && wready && beat_last;
    assign count_clear = (state == LOOKUP) ||
                         ((state == WRITEBACK) && bvalid && (w_done || w_finish));
    assign req_beat = (count == req_word);

    // hit data comes from the store, miss data from the captured beat
    assign rdata = merge_bytes(from_hit ? read_word : rdata_q, req_wdata, store_bytes);

    always_comb begin
        data_write = 1'b0;
        write_bytes = 4'hf;
        write_data = rdata_m;
        tag_write = 1'b0;
        mark_dirty = 1'b0;
        case (state)
            LOOKUP: begin
                if (hit && req_wr) begin
                    data_write = 1'b1;
                    write_bytes = req_wstrb;
                    write_data = req_wdata;
                    mark_dirty = 1'b1;
                end
            end
            REFILL: begin
                if (rvalid && rready) begin
                    data_write = 1'b1;
                    if (req_beat) begin
                        write_data = merge_bytes(rdata_m, req_wdata, store_bytes);
                    end
                    if (rlast) begin
                        tag_write = 1'b1;
                        mark_dirty = req_wr;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            req_addr <= addr[31:2];
            req_wr <= wr;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
        if ((state == REFILL) && rvalid && rready && req_beat) begin
            rdata_q <= rdata_m;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done <= 1'b0;
            from_hit <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            w_done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (en) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    from_hit <= hit;
                    if (hit) begin
                        done <= 1'b1;
                        state <= IDLE;
                    end else if (victim_dirty) begin
                        awvalid <= 1'b1;
                        state <= WRITEBACK;
                    end else begin
                        arvalid <= 1'b1;
                        state <= REFILL;
                    end
                end
                WRITEBACK: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    // one idle cycle per beat while the next word is read
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                        if (beat_last) begin
                            w_done <= 1'b1;
                        end
                    end else if (!awvalid && !wvalid && !w_done) begin
                        wvalid <= 1'b1;
                    end
                    if (bvalid && (w_done || w_finish)) begin
                        wvalid <= 1'b0;
                        w_done <= 1'b0;
                        arvalid <= 1'b1;
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                    end
                    if (rvalid && rready && rlast) begin
                        rready <= 1'b0;
                        done <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // cpu port
    input  logic        en,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [3:0]  wstrb,
    input  logic [31:0] wdata,
    output logic        busy,
    output logic        done,
    output logic [31:0] rdata,
    // read address
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic        arvalid,
    input  logic        arready,
    // read data
    input  logic [31:0] rdata_m,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    // write address
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic        awvalid,
    input  logic        awready,
    // write data and response
    output logic [31:0] wdata_m,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid
);

    logic                    hit;
    logic                    hit_way;
    logic                    victim_way;
    logic                    victim_dirty;
    logic [LEN_TAG-1:0]      victim_tag;
    logic [31:0]             read_word;
    logic                    lookup;
    logic [LEN_INDEX-1:0]    index;
    logic [LEN_WORD_SEL-1:0] word_sel;
    logic                    tag_write;
    logic                    refill_way;
    logic                    mark_dirty;
    logic                    data_write;
    logic                    write_way;
    logic [31:0]             write_data;
    logic [3:0]              write_bytes;
    logic                    count_step;
    logic                    count_clear;
    logic [LEN_WORD_SEL-1:0] count;
    logic                    beat_last;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .wr           (wr),
        .addr         (addr),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .read_word    (read_word),
        .beat_last    (beat_last),
        .count        (count),
        .arready      (arready),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .rdata_m      (rdata_m),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .busy         (busy),
        .done         (done),
        .rdata        (rdata),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .rready       (rready),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .awvalid      (awvalid),
        .wdata_m      (wdata_m),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .lookup       (lookup),
        .index        (index),
        .word_sel     (word_sel),
        .tag_write    (tag_write),
        .refill_way   (refill_way),
        .mark_dirty   (mark_dirty),
        .data_write   (data_write),
        .write_way    (write_way),
        .write_data   (write_data),
        .write_bytes  (write_bytes),
        .count_step   (count_step),
        .count_clear  (count_clear)
    );

    burst_counter u_counter (
        .clk   (clk),
        .rst   (rst),
        .step  (count_step),
        .clear (count_clear),
        .count (count),
        .last  (beat_last)
    );

    // tag is latched by the store on lookup
    tag_store u_tags (
        .clk          (clk),
        .rst          (rst),
        .lookup       (lookup),
        .index        (index),
        .tag          (addr[31 -: LEN_TAG]),
        .tag_write    (tag_write),
        .refill_way   (refill_way),
        .mark_dirty   (mark_dirty),
        .dirty_way    (write_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_store u_data (
        .clk         (clk),
        .index       (index),
        .word_sel    (word_sel),
        .way         (write_way),
        .write       (data_write),
        .write_bytes (write_bytes),
        .write_data  (write_data),
        .read_word   (read_word)
    );

endmodule

`default_nettype wire

/* bench/bench_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module bench_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 5;

    // 10 ns period, first rising edge at 5 ns
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* bench/mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_model
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // read address
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready = 1'b0,
    // read data
    output logic [31:0] rdata_m = '0,
    output logic        rlast = 1'b0,
    output logic        rvalid = 1'b0,
    input  logic        rready,
    // write address
    input  logic [31:0] awaddr,
    input  logic [7:0]  awlen,
    input  logic        awvalid,
    output logic        awready = 1'b0,
    // write data and response
    input  logic [31:0] wdata_m,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready = 1'b0,
    output logic        bvalid = 1'b0
);

    localparam int MEM_WORDS = 1024;

    logic [31:0] words [MEM_WORDS];
    integer      seed = 32'h46a7;
    logic        rst_q = 1'b1;

    // bookkeeping read by the bench
    int          wb_count = 0;
    logic [31:0] wb_addr = '0;
    int          protocol_errors = 0;

    logic [31:0] wr_addr = '0;
    int          wr_beat = 0;
    logic        wr_open = 1'b0;
    logic        b_pending = 1'b0;
    int          b_delay = 0;
    logic [31:0] rd_addr = '0;
    int          rd_beat = 0;
    logic        rd_open = 1'b0;
    logic        r_fire = 1'b0;

    // word i holds byte address 4*i
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            words[i] = 32'(i * 4);
        end
    end

    function automatic int word_index(input logic [31:0] byte_addr);
        return int'(byte_addr[11:2]);
    endfunction

    // ready about three cycles in four
    function logic roll_ready();
        return ($random(seed) & 3) != 0;
    endfunction

    always @(posedge clk) begin
        rst_q <= rst;
    end

    // outputs change on the falling edge; a handshake seen here
    // completes on the next rising edge
    always @(negedge clk) begin
        if (rst_q) begin
            arready = 1'b0;
            rvalid = 1'b0;
            rlast = 1'b0;
            awready = 1'b0;
            wready = 1'b0;
            bvalid = 1'b0;
            wr_open = 1'b0;
            b_pending = 1'b0;
            rd_open = 1'b0;
            r_fire = 1'b0;
        end else begin
            // write response is a one-cycle pulse
            if (bvalid) begin
                bvalid = 1'b0;
            end else if (b_pending) begin
                if (b_delay == 0) begin
                    bvalid = 1'b1;
                    b_pending = 1'b0;
                end else begin
                    b_delay--;
                end
            end

            awready = roll_ready();
            if (awvalid && awready) begin
                if (awlen != 8'(NR_WORDS - 1) || awaddr[LEN_LINE-1:0] != '0 || wr_open) begin
                    protocol_errors++;
                end
                wr_addr = awaddr;
                wr_beat = 0;
                wr_open = 1'b1;
            end

            wready = roll_ready();
            if (wvalid && wready) begin
                if (!wr_open || wr_beat >= NR_WORDS || wlast != (wr_beat == NR_WORDS - 1)) begin
                    protocol_errors++;
                end else begin
                    words[word_index(wr_addr) + wr_beat] = wdata_m;
                    wr_beat++;
                    if (wlast) begin
                        wr_open = 1'b0;
                        wb_count++;
                        wb_addr = wr_addr;
                        b_pending = 1'b1;
                        b_delay = $random(seed) & 1;
                    end
                end
            end

            // read beats, data held until taken
            if (r_fire) begin
                r_fire = 1'b0;
                rvalid = 1'b0;
                rlast = 1'b0;
                rd_beat++;
                if (rd_beat == NR_WORDS) begin
                    rd_open = 1'b0;
                end
            end
            if (rd_open && !rvalid && roll_ready()) begin
                rvalid = 1'b1;
                rdata_m = words[word_index(rd_addr) + rd_beat];
                rlast = (rd_beat == NR_WORDS - 1);
            end
            r_fire = rvalid && rready;

            if (rd_open) begin
                arready = 1'b0;
            end else begin
                arready = roll_ready();
                if (arvalid && arready) begin
                    if (arlen != 8'(NR_WORDS - 1) || araddr[LEN_LINE-1:0] != '0) begin
                        protocol_errors++;
                    end
                    rd_addr = araddr;
                    rd_beat = 0;
                    rd_open = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/dcache_bench.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_bench
    import dcache_pkg::*;
();

    localparam int SET_STRIDE = 1 << (LEN_LINE + LEN_INDEX);
    localparam int LINE_BYTES = 1 << LEN_LINE;
    localparam int SHADOW_WORDS = 1024;
    localparam int DONE_TIMEOUT = 500;
    localparam int HIT_CYCLES = 2;
    localparam int RANDOM_ROWS = 48;
    localparam logic [1:0] KIND_ANY = 2'd0;
    localparam logic [1:0] KIND_HIT = 2'd1;
    localparam logic [1:0] KIND_MISS = 2'd2;

    // kind sets the expected latency class of a row
    typedef struct packed {
        logic        is_store;
        logic [31:0] addr;
        logic [3:0]  strobes;
        logic [31:0] data;
        logic [1:0]  kind;
    } access_row_t;

    logic        clk;
    logic        rst = 1'b1;
    logic        en = 1'b0;
    logic        wr = 1'b0;
    logic [31:0] addr = '0;
    logic [3:0]  wstrb = '0;
    logic [31:0] wdata = '0;
    logic        busy;
    logic        done;
    logic [31:0] rdata;

    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata_m;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata_m;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;

    access_row_t rows [$];
    logic [31:0] shadow [SHADOW_WORDS];
    integer      seed = 32'h46a7;

    bench_clock u_clock (
        .clk (clk)
    );

    mem_model u_mem (
        .clk     (clk),     .rst     (rst),
        .araddr  (araddr),  .arlen   (arlen),   .arvalid (arvalid), .arready (arready),
        .rdata_m (rdata_m), .rlast   (rlast),   .rvalid  (rvalid),  .rready  (rready),
        .awaddr  (awaddr),  .awlen   (awlen),   .awvalid (awvalid), .awready (awready),
        .wdata_m (wdata_m), .wlast   (wlast),   .wvalid  (wvalid),  .wready  (wready),
        .bvalid  (bvalid)
    );

    dcache_top DUT (
        .clk     (clk),     .rst     (rst),
        .en      (en),      .wr      (wr),      .addr    (addr),
        .wstrb   (wstrb),   .wdata   (wdata),
        .busy    (busy),    .done    (done),    .rdata   (rdata),
        .araddr  (araddr),  .arlen   (arlen),   .arvalid (arvalid), .arready (arready),
        .rdata_m (rdata_m), .rlast   (rlast),   .rvalid  (rvalid),  .rready  (rready),
        .awaddr  (awaddr),  .awlen   (awlen),   .awvalid (awvalid), .awready (awready),
        .wdata_m (wdata_m), .wlast   (wlast),   .wvalid  (wvalid),  .wready  (wready),
        .bvalid  (bvalid)
    );

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
        stop_run();
    endtask

    task automatic fail_text(input string what);
        $display("%s at %0t ns", what, $time);
        stop_run();
    endtask

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strobes);
        logic [31:0] mask;
        mask = {{8{strobes[3]}}, {8{strobes[2]}}, {8{strobes[1]}}, {8{strobes[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic logic [31:0] word_addr(input int tag, input int set, input int word);
        return 32'(tag * SET_STRIDE + set * LINE_BYTES + word * 4);
    endfunction

    function automatic void add_row(input logic is_store, input logic [31:0] a,
                                    input logic [3:0] s, input logic [31:0] d,
                                    input logic [1:0] kind);
        access_row_t row;
        row.is_store = is_store;
        row.addr = a;
        row.strobes = s;
        row.data = d;
        row.kind = kind;
        rows.push_back(row);
    endfunction

    function automatic void build_directed_rows();
        // untouched line, then again from the cache
        add_row(1'b0, word_addr(0, 1, 1), 4'h0, 32'h0, KIND_MISS);
        add_row(1'b0, word_addr(0, 1, 2), 4'h0, 32'h0, KIND_HIT);
        // partial store hit
        add_row(1'b1, word_addr(0, 1, 2), 4'b0101, 32'haabbccdd, KIND_HIT);
        add_row(1'b0, word_addr(0, 1, 2), 4'h0, 32'h0, KIND_HIT);
        // store miss merges into the refilled word
        add_row(1'b1, word_addr(0, 2, 3), 4'b1100, 32'h11223344, KIND_MISS);
        add_row(1'b0, word_addr(0, 2, 3), 4'h0, 32'h0, KIND_HIT);
        add_row(1'b0, word_addr(0, 2, 2), 4'h0, 32'h0, KIND_HIT);
        // three tags in set 3, dirty tag 1 gets evicted by tag 3
        add_row(1'b1, word_addr(1, 3, 1), 4'hf, 32'hdeadbeef, KIND_MISS);
        add_row(1'b0, word_addr(2, 3, 2), 4'h0, 32'h0, KIND_MISS);
        add_row(1'b0, word_addr(3, 3, 3), 4'h0, 32'h0, KIND_MISS);
        add_row(1'b0, word_addr(1, 3, 1), 4'h0, 32'h0, KIND_MISS);
    endfunction

    // four tags over sets 4 and 5 keep evictions frequent
    function automatic void build_random_rows();
        int          tag;
        int          set;
        int          word;
        logic        is_store;
        logic [3:0]  strobes;
        logic [31:0] data;
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            tag = $random(seed) & 3;
            set = 4 + ($random(seed) & 1);
            word = $random(seed) & (NR_WORDS - 1);
            is_store = $random(seed) & 1;
            strobes = 4'($random(seed));
            data = $random(seed);
            add_row(is_store, word_addr(tag, set, word), strobes, data, KIND_ANY);
        end
    endfunction

    task automatic run_access(input access_row_t row);
        logic [31:0] expected;
        int          idx;
        int          cycles;
        idx = int'(row.addr[11:2]);
        expected = apply_strobes(shadow[idx], row.data, row.is_store ? row.strobes : 4'h0);
        shadow[idx] = expected;
        en = 1'b1;
        wr = row.is_store;
        addr = row.addr;
        wstrb = row.strobes;
        wdata = row.data;
        @(negedge clk);
        en = 1'b0;
        assert (busy) else fail_text("busy did not rise after an accepted request");
        cycles = 1;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (done) else fail_text("timeout while waiting for done");
        assert (rdata === expected) else fail_value("rdata", rdata, expected);
        if (row.kind == KIND_HIT) begin
            assert (cycles == HIT_CYCLES) else fail_value("hit latency", cycles, HIT_CYCLES);
        end
        if (row.kind == KIND_MISS) begin
            assert (cycles > HIT_CYCLES) else fail_text("a miss completed within hit latency");
        end
    endtask

    task automatic apply_rows(input int first);
        for (int i = first; i < rows.size(); i++) begin
            run_access(rows[i]);
        end
    endtask

    task automatic check_reset_state();
        assert (busy === 1'b0) else fail_value("busy", busy, 0);
        assert (done === 1'b0) else fail_value("done", done, 0);
        assert (arvalid === 1'b0) else fail_value("arvalid", arvalid, 0);
        assert (awvalid === 1'b0) else fail_value("awvalid", awvalid, 0);
        assert (wvalid === 1'b0) else fail_value("wvalid", wvalid, 0);
        assert (rready === 1'b0) else fail_value("rready", rready, 0);
        assert (DUT.u_ctrl.state == IDLE) else fail_text("controller is not idle after reset");
    endtask

    // exactly one write burst, to the evicted tag 1 line of set 3
    task automatic check_eviction();
        logic [31:0] line;
        int          idx;
        line = word_addr(1, 3, 0);
        idx = int'(line[11:2]);
        assert (u_mem.wb_count == 1) else fail_value("write bursts", u_mem.wb_count, 1);
        assert (u_mem.wb_addr === line) else fail_value("awaddr", u_mem.wb_addr, line);
        for (int w = 0; w < NR_WORDS; w++) begin
            assert (u_mem.words[idx + w] === shadow[idx + w])
                else fail_value("memory word", u_mem.words[idx + w], shadow[idx + w]);
        end
    endtask

    initial begin
        int first;
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow[i] = 32'(i * 4);
        end
        build_directed_rows();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        apply_rows(0);
        check_eviction();
        first = rows.size();
        build_random_rows();
        apply_rows(first);
        assert (u_mem.protocol_errors == 0)
            else fail_value("bus protocol errors", u_mem.protocol_errors, 0);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/dcache_pkg.sv
verilog/burst_counter.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/bench_clock.sv
bench/mem_model.sv
bench/dcache_bench.sv
